// ==== compile.f ====
+incdir+.
z80_dp_pkg.sv
dp_decoder.sv
reg_pair.sv
alu8.sv
acc_flags.sv
dp_read_mux.sv
z80_datapath.sv
tb_z80_datapath.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_z80_datapath; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_z80_datapath)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== tb_z80_datapath.sv ====
`timescale 1ns/1ps
`include "z80_dp_macros.svh"

// random micro-operation stimulus, checked against a register-level model
module tb_z80_datapath import z80_dp_pkg::*; ();

  logic        clk;
  logic        rst_n;
  logic        op_valid;
  dp_op_e      op;
  alu_fn_e     alu_fn;
  reg_sel_e    reg_sel;
  logic [7:0]  data_in;
  logic [7:0]  data_out;
  logic        data_valid;
  logic [15:0] addr_out;
  logic        addr_valid;
  logic [7:0]  flags;

  logic [31:0] lfsr;
  // model state where index 0..5 follows B, C, D, E, H and L
  logic [7:0]  m_a;
  logic [7:0]  m_f;
  logic [7:0]  m_a_sh;
  logic [7:0]  m_f_sh;
  logic [7:0]  m_reg [6];
  logic [7:0]  m_reg_sh [6];
  // the outputs hold the last value read while their valid is low
  logic [7:0]  m_last_d;
  logic [15:0] m_last_addr;

  z80_datapath i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_valid   (op_valid),
    .op         (op),
    .alu_fn     (alu_fn),
    .reg_sel    (reg_sel),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_valid (data_valid),
    .addr_out   (addr_out),
    .addr_valid (addr_valid),
    .flags      (flags)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ----------------------------------------------------------
  // random source and error reporting
  // ----------------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr_bit()};
    end
    return v;
  endfunction

  // codes 9..15 fold back onto the real operations
  function automatic dp_op_e rand_op();
    logic [3:0] v;
    v = 4'(rand_bits(4));
    if (v > 4'd8) begin
      v = v - 4'd8;
    end
    return dp_op_e'(v);
  endfunction

  function automatic alu_fn_e rand_fn();
    logic [2:0] v;
    v = 3'(rand_bits(3));
    if (v == 3'd7) begin
      v = 3'd0;
    end
    return alu_fn_e'(v);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped on an error");
  endtask

  // ----------------------------------------------------------
  // reference ALU
  // ----------------------------------------------------------

  // the new F comes back above the result byte
  function automatic logic [15:0] model_alu(input alu_fn_e fn, input logic [7:0] a,
                                            input logic [7:0] b, input logic [7:0] f);
    logic [8:0] t;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] r;
    logic [7:0] nf;
    logic       c_in;
    int         sv;
    nf   = f;
    c_in = (fn == ALU_ADC) ? f[`FLAG_C] : 1'b0;
    // INC adds one to the register itself
    x = (fn == ALU_INC) ? b : a;
    y = (fn == ALU_INC) ? 8'd1 : b;
    case (fn)
      ALU_ADD, ALU_ADC, ALU_INC: begin
        t  = {1'b0, x} + {1'b0, y} + {8'd0, c_in};
        sv = int'($signed(x)) + int'($signed(y)) + int'(c_in);
        r  = t[7:0];
        // carry into bit 4 is the carry out of bit 3
        nf[`FLAG_H]  = x[4] ^ y[4] ^ r[4];
        nf[`FLAG_PV] = (sv > 127) || (sv < -128);
        nf[`FLAG_N]  = 1'b0;
        if (fn != ALU_INC) begin
          nf[`FLAG_C] = t[8];
        end
      end
      ALU_SUB: begin
        t  = {1'b0, a} - {1'b0, b};
        sv = int'($signed(a)) - int'($signed(b));
        r  = t[7:0];
        nf[`FLAG_H]  = a[4] ^ b[4] ^ r[4];
        nf[`FLAG_PV] = (sv > 127) || (sv < -128);
        nf[`FLAG_N]  = 1'b1;
        nf[`FLAG_C]  = (a < b);
      end
      ALU_AND, ALU_OR: begin
        r = (fn == ALU_AND) ? (a & b) : (a | b);
        nf[`FLAG_H]  = (fn == ALU_AND);
        nf[`FLAG_PV] = ~^r;
        nf[`FLAG_N]  = 1'b0;
        nf[`FLAG_C]  = 1'b0;
      end
      default: begin
        r = ~a;
        nf[`FLAG_H] = 1'b1;
        nf[`FLAG_N] = 1'b1;
      end
    endcase
    if (fn != ALU_CPL) begin
      nf[`FLAG_S] = r[7];
      nf[`FLAG_Z] = (r == 8'h00);
    end
    return {nf, r};
  endfunction

  // ----------------------------------------------------------
  // one strobed operation with its model update and response check
  // ----------------------------------------------------------
  task automatic strobe(input dp_op_e o, input alu_fn_e fn, input logic [2:0] s,
                        input logic [7:0] d);
    logic        sel_ok;
    logic        exp_dv;
    logic        exp_av;
    logic [7:0]  exp_d;
    logic [15:0] exp_addr;
    logic [15:0] alu_out;
    logic [7:0]  tmp;
    int          cycles;
    sel_ok   = (s < 3'd6);
    exp_dv   = 1'b0;
    exp_av   = 1'b0;
    exp_d    = m_last_d;
    exp_addr = m_last_addr;
    op_valid = 1'b1;
    op       = o;
    alu_fn   = fn;
    reg_sel  = reg_sel_e'(s);
    data_in  = d;
    // reads see the state from before the edge, so they go first
    case (o)
      OP_LD_REG: begin
        if (sel_ok) begin
          m_reg[s] = d;
        end
      end
      OP_LD_A: m_a = d;
      OP_OUT_REG: begin
        exp_dv = sel_ok;
        if (sel_ok) begin
          exp_d = m_reg[s];
        end
      end
      OP_OUT_A: begin
        exp_dv = 1'b1;
        exp_d  = m_a;
      end
      OP_OUT_PAIR: begin
        exp_av = sel_ok;
        if (sel_ok) begin
          exp_addr = {m_reg[{s[2:1], 1'b0}], m_reg[{s[2:1], 1'b1}]};
        end
      end
      OP_ALU: begin
        if (fn == ALU_CPL) begin
          alu_out = model_alu(fn, m_a, 8'h00, m_f);
          m_a     = alu_out[7:0];
          m_f     = alu_out[15:8];
        end else if (sel_ok) begin
          alu_out = model_alu(fn, m_a, m_reg[s], m_f);
          m_f     = alu_out[15:8];
          if (fn == ALU_INC) begin
            m_reg[s] = alu_out[7:0];
          end else begin
            m_a = alu_out[7:0];
          end
        end
      end
      OP_EXX: begin
        for (int i = 0; i < 6; i++) begin
          tmp         = m_reg[i];
          m_reg[i]    = m_reg_sh[i];
          m_reg_sh[i] = tmp;
        end
      end
      OP_EX_AF: begin
        tmp    = m_a;
        m_a    = m_a_sh;
        m_a_sh = tmp;
        tmp    = m_f;
        m_f    = m_f_sh;
        m_f_sh = tmp;
      end
      default: ;
    endcase
    m_last_d    = exp_d;
    m_last_addr = exp_addr;
    // wait for the edge, and for a read's valid strobe
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      op_valid = 1'b0;
      cycles++;
    end while ((exp_dv || exp_av) && !(data_valid || addr_valid) && cycles < 8);
    if ((exp_dv || exp_av) && !(data_valid || addr_valid)) begin
      abort_run("a read got no valid strobe back within 8 cycles");
    end
    assert (cycles == 1)
      else report_mismatch($sformatf("read answered after %0d cycles", cycles));
    assert (data_valid === exp_dv)
      else report_mismatch($sformatf("op %s data_valid %0b, expected %0b",
                                     o.name(), data_valid, exp_dv));
    assert (addr_valid === exp_av)
      else report_mismatch($sformatf("op %s addr_valid %0b, expected %0b",
                                     o.name(), addr_valid, exp_av));
    assert (data_out === exp_d)
      else report_mismatch($sformatf("op %s sel %0d data_out %h, expected %h",
                                     o.name(), s, data_out, exp_d));
    assert (addr_out === exp_addr)
      else report_mismatch($sformatf("op %s sel %0d addr_out %h, expected %h",
                                     o.name(), s, addr_out, exp_addr));
    assert (flags === m_f)
      else report_mismatch($sformatf("op %s fn %s flags %h, expected %h",
                                     o.name(), fn.name(), flags, m_f));
  endtask

  // a gap cycle with junk on the inputs and op_valid low
  task automatic idle_cycle();
    op_valid = 1'b0;
    op       = rand_op();
    reg_sel  = reg_sel_e'(3'(rand_bits(3)));
    data_in  = rand_bits(8);
    @(posedge clk);
    #1;
    assert (!data_valid && !addr_valid)
      else report_mismatch("valid strobe in a cycle with no read");
    assert (data_out === m_last_d)
      else report_mismatch($sformatf("idle data_out %h, expected %h", data_out, m_last_d));
    assert (addr_out === m_last_addr)
      else report_mismatch($sformatf("idle addr_out %h, expected %h", addr_out, m_last_addr));
    assert (flags === m_f)
      else report_mismatch($sformatf("idle flags %h, expected %h", flags, m_f));
  endtask

  initial begin
    logic [2:0] s;
    lfsr        = 32'h3898;
    rst_n       = 1'b0;
    op_valid    = 1'b0;
    op          = OP_NOP;
    alu_fn      = ALU_ADD;
    reg_sel     = REG_B;
    data_in     = '0;
    m_a         = '0;
    m_f         = '0;
    m_a_sh      = '0;
    m_f_sh      = '0;
    m_last_d    = '0;
    m_last_addr = '0;
    for (int i = 0; i < 6; i++) begin
      m_reg[i]    = '0;
      m_reg_sh[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // quiet outputs and a zero accumulator after reset
    idle_cycle();
    idle_cycle();
    strobe(OP_OUT_A, ALU_ADD, 3'd0, 8'h00);

    // every byte register, then the three pairs
    for (int i = 0; i < 6; i++) begin
      strobe(OP_LD_REG, ALU_ADD, 3'(i), rand_bits(8));
      strobe(OP_OUT_REG, ALU_ADD, 3'(i), 8'h00);
    end
    for (int i = 0; i < 6; i += 2) begin
      strobe(OP_OUT_PAIR, ALU_ADD, 3'(i), 8'h00);
    end

    // random ALU work, INC lands in the register
    for (int n = 0; n < 300; n++) begin
      s = 3'(rand_bits(3) % 6);
      strobe(OP_LD_A, ALU_ADD, 3'd0, rand_bits(8));
      strobe(OP_LD_REG, ALU_ADD, s, rand_bits(8));
      strobe(OP_ALU, rand_fn(), s, 8'h00);
      strobe(OP_OUT_A, ALU_ADD, 3'd0, 8'h00);
      strobe(OP_OUT_REG, ALU_ADD, s, 8'h00);
    end

    // first set becomes the shadow, second set the main registers
    for (int i = 0; i < 6; i++) begin
      strobe(OP_LD_REG, ALU_ADD, 3'(i), rand_bits(8));
    end
    strobe(OP_EXX, ALU_ADD, 3'd0, 8'h00);
    for (int i = 0; i < 6; i++) begin
      strobe(OP_LD_REG, ALU_ADD, 3'(i), rand_bits(8));
    end
    for (int k = 0; k < 3; k++) begin
      strobe(OP_EXX, ALU_ADD, 3'd0, 8'h00);
      for (int i = 0; i < 6; i += 2) begin
        strobe(OP_OUT_PAIR, ALU_ADD, 3'(i), 8'h00);
      end
    end

    // EX AF shows on both flags and A
    for (int n = 0; n < 20; n++) begin
      strobe(OP_LD_A, ALU_ADD, 3'd0, rand_bits(8));
      strobe(OP_ALU, rand_fn(), 3'(rand_bits(3) % 6), 8'h00);
      strobe(OP_EX_AF, ALU_ADD, 3'd0, 8'h00);
      strobe(OP_OUT_A, ALU_ADD, 3'd0, 8'h00);
    end

    // long mix with gaps, back-to-back strobes and selects 6 and 7
    for (int n = 0; n < 3000; n++) begin
      if (rand_bits(2) == 8'd0) begin
        idle_cycle();
      end else begin
        strobe(rand_op(), rand_fn(), 3'(rand_bits(3)), rand_bits(8));
      end
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== z80_datapath.sv ====
`timescale 1ns/1ps
`include "z80_dp_macros.svh"

// top of the cut-down Z80 accumulator datapath
module z80_datapath import z80_dp_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  op_valid,
  input  dp_op_e                op,
  input  alu_fn_e               alu_fn,
  input  reg_sel_e              reg_sel,
  input  logic [`DP_BYTE_W-1:0] data_in,
  output logic [`DP_BYTE_W-1:0] data_out,
  output logic                  data_valid,
  output logic [`DP_ADDR_W-1:0] addr_out,
  output logic                  addr_valid,
  output logic [`DP_BYTE_W-1:0] flags
);

  logic [`DP_NUM_PAIRS-1:0]            ld_hi;
  logic [`DP_NUM_PAIRS-1:0]            ld_lo;
  logic                                exx;
  logic [`DP_BYTE_W-1:0]               pair_d;
  logic                                ld_a;
  logic                                alu_en;
  logic                                ex_af;
  logic                                rd_reg;
  logic                                rd_a;
  logic                                rd_pair;
  logic [`DP_NUM_PAIRS*`DP_ADDR_W-1:0] pairs;
  logic [`DP_BYTE_W-1:0]               operand;
  logic [`DP_BYTE_W-1:0]               a_q;
  logic [`DP_BYTE_W-1:0]               alu_res;

  dp_decoder i_decoder (
    .op_valid (op_valid),
    .op       (op),
    .alu_fn   (alu_fn),
    .reg_sel  (reg_sel),
    .data_in  (data_in),
    .alu_res  (alu_res),
    .ld_hi    (ld_hi),
    .ld_lo    (ld_lo),
    .exx      (exx),
    .pair_d   (pair_d),
    .ld_a     (ld_a),
    .alu_en   (alu_en),
    .ex_af    (ex_af),
    .rd_reg   (rd_reg),
    .rd_a     (rd_a),
    .rd_pair  (rd_pair)
  );

  // BC, DE and HL in that order, pair 0 in the low bits of pairs
  for (genvar g = 0; g < `DP_NUM_PAIRS; g++) begin : g_pair
    reg_pair i_pair (
      .clk    (clk),
      .rst_n  (rst_n),
      .ld_hi  (ld_hi[g]),
      .ld_lo  (ld_lo[g]),
      .exx    (exx),
      .d      (pair_d),
      .pair_q (pairs[g*`DP_ADDR_W +: `DP_ADDR_W])
    );
  end

  acc_flags i_acc (
    .clk     (clk),
    .rst_n   (rst_n),
    .ld_a    (ld_a),
    .alu_en  (alu_en),
    .ex_af   (ex_af),
    .alu_fn  (alu_fn),
    .data_in (data_in),
    .operand (operand),
    .a_q     (a_q),
    .f_q     (flags),
    .alu_res (alu_res)
  );

  dp_read_mux i_read_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .pairs      (pairs),
    .reg_sel    (reg_sel),
    .a_q        (a_q),
    .rd_reg     (rd_reg),
    .rd_a       (rd_a),
    .rd_pair    (rd_pair),
    .operand    (operand),
    .data_out   (data_out),
    .data_valid (data_valid),
    .addr_out   (addr_out),
    .addr_valid (addr_valid)
  );

endmodule

// ==== dp_read_mux.sv ====
`timescale 1ns/1ps
`include "z80_dp_macros.svh"

// picks the operand byte and registers the data and address outputs
module dp_read_mux import z80_dp_pkg::*; (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [`DP_NUM_PAIRS*`DP_ADDR_W-1:0] pairs,
  input  reg_sel_e                            reg_sel,
  input  logic [`DP_BYTE_W-1:0]               a_q,
  input  logic                                rd_reg,
  input  logic                                rd_a,
  input  logic                                rd_pair,
  output logic [`DP_BYTE_W-1:0]               operand,
  output logic [`DP_BYTE_W-1:0]               data_out,
  output logic                                data_valid,
  output logic [`DP_ADDR_W-1:0]               addr_out,
  output logic                                addr_valid
);

  logic [`DP_ADDR_W-1:0] sel_pair;

  // ----------------------------------------------------------
  // combinational operand path
  // ----------------------------------------------------------

  // a select past the last pair reads zero and is never acted on
  always_comb begin
    sel_pair = '0;
    for (int i = 0; i < `DP_NUM_PAIRS; i++) begin
      if (reg_sel[2:1] == 2'(i)) begin
        sel_pair = pairs[i*`DP_ADDR_W +: `DP_ADDR_W];
      end
    end
  end

  // even selects name the high byte
  assign operand = reg_sel[0] ? sel_pair[`DP_BYTE_W-1:0]
                              : sel_pair[`DP_ADDR_W-1:`DP_BYTE_W];

  // ----------------------------------------------------------
  // output registers, each value holds while its valid is low
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out   <= '0;
      data_valid <= 1'b0;
      addr_out   <= '0;
      addr_valid <= 1'b0;
    end else begin
      data_valid <= rd_reg || rd_a;
      addr_valid <= rd_pair;
      // the values sampled here are the state before this edge
      if (rd_a) begin
        data_out <= a_q;
      end else if (rd_reg) begin
        data_out <= operand;
      end
      if (rd_pair) begin
        addr_out <= sel_pair;
      end
    end
  end

endmodule

// ==== acc_flags.sv ====
`timescale 1ns/1ps
`include "z80_dp_macros.svh"

// the accumulator and flag register, their shadows, and the ALU that feeds them
module acc_flags import z80_dp_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ld_a,
  input  logic                  alu_en,
  input  logic                  ex_af,
  input  alu_fn_e               alu_fn,
  input  logic [`DP_BYTE_W-1:0] data_in,
  input  logic [`DP_BYTE_W-1:0] operand,
  output logic [`DP_BYTE_W-1:0] a_q,
  output logic [`DP_BYTE_W-1:0] f_q,
  output logic [`DP_BYTE_W-1:0] alu_res
);

  logic [`DP_BYTE_W-1:0] a_sh;
  logic [`DP_BYTE_W-1:0] f_sh;
  logic [`DP_BYTE_W-1:0] f_next;

  // A is always the left operand, the selected register the right one
  alu8 i_alu (
    .fn    (alu_fn),
    .a     (a_q),
    .b     (operand),
    .f_in  (f_q),
    .res   (alu_res),
    .f_out (f_next)
  );

  // ----------------------------------------------------------
  // A and F with the EX AF exchange
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q  <= '0;
      f_q  <= '0;
      a_sh <= '0;
      f_sh <= '0;
    end else if (ex_af) begin
      a_q  <= a_sh;
      f_q  <= f_sh;
      a_sh <= a_q;
      f_sh <= f_q;
    end else if (ld_a) begin
      a_q <= data_in;
    end else if (alu_en) begin
      f_q <= f_next;
      // the INC result belongs to the register pair, so A keeps its value
      if (alu_fn != ALU_INC) begin
        a_q <= alu_res;
      end
    end
  end

endmodule

// ==== alu8.sv ====
`timescale 1ns/1ps
`include "z80_dp_macros.svh"

// combinational 8-bit ALU with Z80 flag generation
module alu8 import z80_dp_pkg::*; (
  input  alu_fn_e               fn,
  input  logic [`DP_BYTE_W-1:0] a,
  input  logic [`DP_BYTE_W-1:0] b,
  input  logic [`DP_BYTE_W-1:0] f_in,
  output logic [`DP_BYTE_W-1:0] res,
  output logic [`DP_BYTE_W-1:0] f_out
);

  logic                  cin;
  logic [`DP_BYTE_W:0]   sum;
  logic [4:0]            sum_lo;
  logic [`DP_BYTE_W:0]   diff;
  logic [`DP_BYTE_W-1:0] inc;

  // carry in only for ADC
  assign cin = (fn == ALU_ADC) ? f_in[`FLAG_C] : 1'b0;

  // the top bit of each sum is the carry out of bit 7
  assign sum    = {1'b0, a} + {1'b0, b} + {{`DP_BYTE_W{1'b0}}, cin};
  // a separate nibble add gives the carry out of bit 3 for H
  assign sum_lo = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0000, cin};
  // a borrow shows up as the top bit of the widened difference
  assign diff   = {1'b0, a} - {1'b0, b};
  // INC works on the selected register, which arrives on b
  assign inc    = b + 1'b1;

  always_comb begin
    res   = a;
    f_out = f_in;
    case (fn)
      ALU_ADD, ALU_ADC: begin
        res              = sum[`DP_BYTE_W-1:0];
        f_out[`FLAG_H]  = sum_lo[4];
        // overflow when both inputs share a sign that the result lost
        f_out[`FLAG_PV] = (a[7] == b[7]) && (res[7] != a[7]);
        f_out[`FLAG_N]  = 1'b0;
        f_out[`FLAG_C]  = sum[`DP_BYTE_W];
      end
      ALU_SUB: begin
        res              = diff[`DP_BYTE_W-1:0];
        // borrow from bit 4 means the low nibble of a was too small
        f_out[`FLAG_H]  = (a[3:0] < b[3:0]);
        f_out[`FLAG_PV] = (a[7] != b[7]) && (res[7] != a[7]);
        f_out[`FLAG_N]  = 1'b1;
        f_out[`FLAG_C]  = diff[`DP_BYTE_W];
      end
      ALU_AND: begin
        res              = a & b;
        f_out[`FLAG_H]  = 1'b1;
        // PV is even parity for the logic functions
        f_out[`FLAG_PV] = ~^res;
        f_out[`FLAG_N]  = 1'b0;
        f_out[`FLAG_C]  = 1'b0;
      end
      ALU_OR: begin
        res              = a | b;
        f_out[`FLAG_H]  = 1'b0;
        f_out[`FLAG_PV] = ~^res;
        f_out[`FLAG_N]  = 1'b0;
        f_out[`FLAG_C]  = 1'b0;
      end
      ALU_INC: begin
        // carry is left alone, only the half carry and overflow move
        res              = inc;
        f_out[`FLAG_H]  = (b[3:0] == 4'hf);
        f_out[`FLAG_PV] = (b == 8'h7f);
        f_out[`FLAG_N]  = 1'b0;
      end
      ALU_CPL: begin
        // the complement touches only H and N
        res              = ~a;
        f_out[`FLAG_H]  = 1'b1;
        f_out[`FLAG_N]  = 1'b1;
      end
      default: begin
        res = a;
      end
    endcase
    // S and Z track the result for every defined function below CPL
    if (fn < ALU_CPL) begin
      f_out[`FLAG_S] = res[7];
      f_out[`FLAG_Z] = (res == '0);
    end
    // bits 5 and 3 are not modelled and read as zero
    f_out[5] = 1'b0;
    f_out[3] = 1'b0;
  end

endmodule

// ==== reg_pair.sv ====
`timescale 1ns/1ps
`include "z80_dp_macros.svh"

// one register pair (BC, DE or HL) together with its shadow pair
module reg_pair (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ld_hi,
  input  logic                  ld_lo,
  input  logic                  exx,
  input  logic [`DP_BYTE_W-1:0] d,
  output logic [`DP_ADDR_W-1:0] pair_q
);

  // main bytes are the ones visible to the rest of the datapath
  logic [`DP_BYTE_W-1:0] hi_q;
  logic [`DP_BYTE_W-1:0] lo_q;
  // shadow bytes are only reachable through the exchange
  logic [`DP_BYTE_W-1:0] hi_sh;
  logic [`DP_BYTE_W-1:0] lo_sh;

  // ----------------------------------------------------------
  // byte loads and the single-cycle exchange
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hi_q  <= '0;
      lo_q  <= '0;
      hi_sh <= '0;
      lo_sh <= '0;
    end else if (exx) begin
      // both halves swap at once, main and shadow trade places
      hi_q  <= hi_sh;
      lo_q  <= lo_sh;
      hi_sh <= hi_q;
      lo_sh <= lo_q;
    end else begin
      if (ld_hi) begin
        hi_q <= d;
      end
      if (ld_lo) begin
        lo_q <= d;
      end
    end
  end

  // high byte sits in the upper half, as B in BC
  assign pair_q = {hi_q, lo_q};

endmodule

// ==== dp_decoder.sv ====
`timescale 1ns/1ps
`include "z80_dp_macros.svh"

// turns the strobed micro-operation into load, exchange and read enables
module dp_decoder import z80_dp_pkg::*; (
  input  logic                     op_valid,
  input  dp_op_e                   op,
  input  alu_fn_e                  alu_fn,
  input  reg_sel_e                 reg_sel,
  input  logic [`DP_BYTE_W-1:0]    data_in,
  input  logic [`DP_BYTE_W-1:0]    alu_res,
  output logic [`DP_NUM_PAIRS-1:0] ld_hi,
  output logic [`DP_NUM_PAIRS-1:0] ld_lo,
  output logic                     exx,
  output logic [`DP_BYTE_W-1:0]    pair_d,
  output logic                     ld_a,
  output logic                     alu_en,
  output logic                     ex_af,
  output logic                     rd_reg,
  output logic                     rd_a,
  output logic                     rd_pair
);

  logic sel_ok;
  logic is_inc;
  logic wr_reg;

  // selects 6 and 7 name no register, so anything that uses them does nothing
  assign sel_ok = (reg_sel <= REG_L);
  assign is_inc = (op == OP_ALU) && (alu_fn == ALU_INC);

  // INC writes back into the selected byte just like a load does
  assign wr_reg = op_valid && sel_ok && ((op == OP_LD_REG) || is_inc);

  // one-hot byte enables, the pair index is the select divided by two
  always_comb begin
    for (int i = 0; i < `DP_NUM_PAIRS; i++) begin
      ld_hi[i] = wr_reg && (reg_sel[2:1] == 2'(i)) && !reg_sel[0];
      ld_lo[i] = wr_reg && (reg_sel[2:1] == 2'(i)) && reg_sel[0];
    end
  end

  // the pairs take the incremented byte during INC and data_in otherwise
  assign pair_d = is_inc ? alu_res : data_in;

  assign exx   = op_valid && (op == OP_EXX);
  assign ex_af = op_valid && (op == OP_EX_AF);
  assign ld_a  = op_valid && (op == OP_LD_A);

  // CPL works on A alone, every other ALU function reads the selected register
  assign alu_en = op_valid && (op == OP_ALU) && (sel_ok || (alu_fn == ALU_CPL));

  // read requests, each one turns into a one-cycle valid on the outputs
  assign rd_reg  = op_valid && (op == OP_OUT_REG) && sel_ok;
  assign rd_a    = op_valid && (op == OP_OUT_A);
  assign rd_pair = op_valid && (op == OP_OUT_PAIR) && sel_ok;

endmodule

// ==== z80_dp_pkg.sv ====
package z80_dp_pkg;

  // micro-operation carried on the op strobe, one per cycle
  typedef enum logic [3:0] {
    OP_NOP      = 4'd0,
    OP_LD_REG   = 4'd1,
    OP_LD_A     = 4'd2,
    OP_OUT_REG  = 4'd3,
    OP_OUT_A    = 4'd4,
    OP_OUT_PAIR = 4'd5,
    OP_ALU      = 4'd6,
    OP_EXX      = 4'd7,
    OP_EX_AF    = 4'd8
  } dp_op_e;

  // function of the 8-bit ALU, the order matters to alu8
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_ADC = 3'd1,
    ALU_SUB = 3'd2,
    ALU_AND = 3'd3,
    ALU_OR  = 3'd4,
    ALU_INC = 3'd5,
    ALU_CPL = 3'd6
  } alu_fn_e;

  // byte register select, bits 2:1 give the pair and bit 0 the low byte
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5
  } reg_sel_e;

endpackage

// ==== z80_dp_macros.svh ====
`ifndef Z80_DP_MACROS_SVH
`define Z80_DP_MACROS_SVH

// ----------------------------------------------------------
// datapath widths, fixed by the Z80 architecture
// ----------------------------------------------------------

// one data byte
`define DP_BYTE_W     8
// one register pair as seen on the address output
`define DP_ADDR_W     16
// BC, DE and HL
`define DP_NUM_PAIRS  3

// ----------------------------------------------------------
// bit positions inside the F register
// ----------------------------------------------------------
`define FLAG_S   7
`define FLAG_Z   6
`define FLAG_H   4
`define FLAG_PV  2
`define FLAG_N   1
`define FLAG_C   0

`endif
